// ==== hw/audio_cfg_pkg.sv ====
// Audio settings, compressor mode and fixed compressor curve constants
`default_nettype none

package audio_cfg_pkg;

	////////////////////////////////////////////////////////////
	// Setting types
	////////////////////////////////////////////////////////////

	// Volume as a left shift, term times 2**value
	typedef logic [1:0] vol_shift_t;

	// Zero is off, bit 1 picks curve B over curve A
	typedef logic [1:0] comp_mode_t;

	typedef struct packed {
		vol_shift_t spk_vol;
		vol_shift_t psg_vol;
		comp_mode_t comp_mode;
	} audio_cfg_t;

	////////////////////////////////////////////////////////////
	// Compressor curves
	////////////////////////////////////////////////////////////

	// Knee is where the linear gain segment meets the flat segment,
	// (32767 * (factor - 1)) / (factor * gain - 1) + 1, base = knee * gain

	// Curve A, gentle
	localparam int COMP_A_FACTOR = 4;
	localparam int COMP_A_GAIN   = 2;
	localparam int COMP_A_KNEE   = 14044;
	localparam int COMP_A_BASE   = 28088;

	// Curve B, strong
	localparam int COMP_B_FACTOR = 8;
	localparam int COMP_B_GAIN   = 4;
	localparam int COMP_B_KNEE   = 7400;
	localparam int COMP_B_BASE   = 29600;

	////////////////////////////////////////////////////////////
	// Source weights
	////////////////////////////////////////////////////////////

	// One generator step before the volume shift
	localparam int PSG_TERM_SCALE  = 16;

	// Speaker cone driven, before the volume shift
	localparam int SPK_TERM_WEIGHT = 2048;

endpackage

`default_nettype wire

// ==== hw/audio_types_pkg.sv ====
// Audio sample types and the packed structs that carry samples between stages
`default_nettype none

package audio_types_pkg;

	////////////////////////////////////////////////////////////
	// Source sample widths
	////////////////////////////////////////////////////////////

	// FM synthesizer output, two's complement
	typedef logic signed [15:0] fm_sample_t;

	// Sound generator level, unsigned
	typedef logic [7:0] psg_level_t;

	// One scaled source term, one bit of headroom over the output
	typedef logic signed [16:0] mix_term_t;

	// Final output sample
	typedef logic signed [15:0] audio_sample_t;

	////////////////////////////////////////////////////////////
	// Stage bundles
	////////////////////////////////////////////////////////////

	// Raw source levels, speaker is active low
	typedef struct packed {
		fm_sample_t fm;
		psg_level_t psg;
		logic       speaker;
	} snd_src_t;

	// Scaled terms handed from capture to the mixer
	typedef struct packed {
		mix_term_t fm_term;
		mix_term_t psg_term;
		mix_term_t spk_term;
	} snd_terms_t;

endpackage

`default_nettype wire

// ==== hw/pcxt_audio_top.sv ====
// Audio path top level, capture then mixer then compressor
`default_nettype none

module pcxt_audio_top
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input  logic          clk_chipset,
	input  logic          reset,
	input  snd_src_t      src,
	input  audio_cfg_t    cfg,
	output audio_sample_t audio_out
);

	// Scaled terms, capture to mixer
	snd_terms_t terms;

	// Clamped mix, mixer to compressor
	audio_sample_t mix;

	////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////

	snd_capture capture_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.src         (src),
		.cfg         (cfg),
		.terms       (terms)
	);

	snd_mixer mixer_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.terms       (terms),
		.mix         (mix)
	);

	// Mode goes straight through, the output select is combinational
	snd_compressor compressor_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.mix         (mix),
		.comp_mode   (cfg.comp_mode),
		.audio_out   (audio_out)
	);

endmodule

`default_nettype wire

// ==== hw/snd_capture.sv ====
// Source capture with stability filter and volume scaling of the three sources
`default_nettype none

module snd_capture
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input  logic       clk_chipset,
	input  logic       reset,
	input  snd_src_t   src,
	input  audio_cfg_t cfg,
	output snd_terms_t terms
);

	////////////////////////////////////////////////////////////
	// Stability filter
	////////////////////////////////////////////////////////////

	// Two sample stages per source, held copy moves only on agreement
	fm_sample_t fm_s0;
	fm_sample_t fm_s1;
	fm_sample_t fm_held;

	psg_level_t psg_s0;
	psg_level_t psg_s1;
	psg_level_t psg_held;

	// Speaker is a single bit, no filter
	mix_term_t spk_term_q;

	// Generator level widened for scaling
	mix_term_t psg_ext;

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			fm_s0    <= '0;
			fm_s1    <= '0;
			fm_held  <= '0;
			psg_s0   <= '0;
			psg_s1   <= '0;
			psg_held <= '0;
		end else begin
			fm_s0  <= src.fm;
			fm_s1  <= fm_s0;
			psg_s0 <= src.psg;
			psg_s1 <= psg_s0;

			// Seen on two edges in a row
			if (fm_s0 == fm_s1)
				fm_held <= fm_s1;
			if (psg_s0 == psg_s1)
				psg_held <= psg_s1;
		end
	end

	////////////////////////////////////////////////////////////
	// Speaker term
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			spk_term_q <= '0;
		end else if (!src.speaker) begin
			// Low level drives the cone
			spk_term_q <= mix_term_t'(SPK_TERM_WEIGHT << cfg.spk_vol);
		end else begin
			spk_term_q <= '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Term assembly
	////////////////////////////////////////////////////////////

	assign psg_ext = {9'd0, psg_held};

	always_comb begin
		// FM is already signed, sign extend only
		terms.fm_term  = mix_term_t'(fm_held);
		// At most 255 * 8 * 16, stays positive in 17 bits
		terms.psg_term = mix_term_t'((psg_ext <<< cfg.psg_vol) * PSG_TERM_SCALE);
		terms.spk_term = spk_term_q;
	end

endmodule

`default_nettype wire

// ==== hw/snd_compressor.sv ====
// Two-curve dynamic range compressor with output select by compressor mode
`default_nettype none

module snd_compressor
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input  logic          clk_chipset,
	input  logic          reset,
	input  audio_sample_t mix,
	input  comp_mode_t    comp_mode,
	output audio_sample_t audio_out
);

	////////////////////////////////////////////////////////////
	// Curve shape
	////////////////////////////////////////////////////////////

	// Linear gain below the knee, flattened slope above it
	function automatic logic [16:0] curve_value(
		input logic [15:0] mag,
		input int          knee,
		input int          gain,
		input int          factor,
		input int          base
	);
		logic [16:0] below;
		logic [16:0] above;
		begin
			below = 17'(mag * gain);
			above = 17'(((mag - knee) / factor) + base);
			return (mag < knee) ? below : above;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Magnitude path
	////////////////////////////////////////////////////////////

	logic [15:0]   mag;
	logic [16:0]   curve_a;
	logic [16:0]   curve_b;
	logic [16:0]   picked;
	logic [15:0]   limited;
	audio_sample_t shaped;

	// Registered compressed sample
	audio_sample_t compressed;

	always_comb begin
		// 8000 maps to 32768, still fits unsigned
		mag     = mix[15] ? 16'(-mix) : 16'(mix);
		curve_a = curve_value(mag, COMP_A_KNEE, COMP_A_GAIN, COMP_A_FACTOR, COMP_A_BASE);
		curve_b = curve_value(mag, COMP_B_KNEE, COMP_B_GAIN, COMP_B_FACTOR, COMP_B_BASE);
		picked  = comp_mode[1] ? curve_b : curve_a;

		// Near full scale the flat segment runs a few counts past 7fff,
		// limit so the restored sign stays right
		if (picked > 17'd32767)
			limited = 16'h7fff;
		else
			limited = picked[15:0];

		// Restore sign
		shaped = mix[15] ? (~limited + 16'd1) : limited;
	end

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			compressed <= '0;
		end else begin
			compressed <= shaped;
		end
	end

	////////////////////////////////////////////////////////////
	// Output select
	////////////////////////////////////////////////////////////

	// Mode change shows at the output in the same cycle
	assign audio_out = (comp_mode != '0) ? compressed : mix;

endmodule

`default_nettype wire

// ==== hw/snd_mixer.sv ====
// Mixer stage, registered 17-bit sum of the source terms and clamp to 16 bits
`default_nettype none

module snd_mixer
	import audio_types_pkg::*;
(
	input  logic          clk_chipset,
	input  logic          reset,
	input  snd_terms_t    terms,
	output audio_sample_t mix
);

	// Sum stage, wraps in 17 bits
	mix_term_t sum;

	// Clamped sample before it leaves the stage
	audio_sample_t clamped;

	// Top two bits differ when the sum left the 16-bit range
	logic overflow;

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			sum <= '0;
		end else begin
			sum <= terms.fm_term + terms.psg_term + terms.spk_term;
		end
	end

	assign overflow = sum[16] ^ sum[15];

	always_comb begin
		if (overflow) begin
			// Negative sum gives 8000, positive gives 7fff
			clamped = {sum[16], {15{~sum[16]}}};
		end else begin
			clamped = sum[15:0];
		end
	end

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			mix <= '0;
		end else begin
			mix <= clamped;
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
hw/audio_types_pkg.sv
hw/audio_cfg_pkg.sv
hw/snd_capture.sv
hw/snd_mixer.sv
hw/snd_compressor.sv
hw/pcxt_audio_top.sv
verif/pcxt_audio_sva.sv
verif/pcxt_audio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --timescale 1ns/100ps --top-module pcxt_audio_tb \
	-f project.f -o pcxt_audio_sim &&
./obj_dir/pcxt_audio_sim > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

// ==== verif/audio_trace.txt ====
# test fm psg speaker spk_vol psg_vol comp_mode glitch expected, all hex
# speaker 0 drives the cone, glitch 1 flips fm every cycle
01 1234 00 1 0 0 0 0 1234
02 ec00 00 1 0 0 0 0 ec00
03 0000 20 1 0 0 0 0 0200
04 0000 ff 1 0 3 0 0 7f80
05 0000 00 0 0 0 0 0 0800
06 0000 00 0 3 0 0 0 4000
07 0000 00 1 3 0 0 0 0000
08 1000 10 0 0 1 0 0 1a00
09 7000 80 0 1 0 0 0 7fff
0a 8100 10 0 0 0 0 0 8a00
0b 03e8 00 1 0 0 1 0 07d0
0c 4e20 00 1 0 0 1 0 7389
0d fc18 00 1 0 0 1 0 f830
0e b1e0 00 1 0 0 1 0 8c77
0f 8000 00 1 0 0 1 0 8001
10 03e8 00 1 0 0 2 0 0fa0
11 2710 00 1 0 0 3 0 74e5
12 7fff 00 1 0 0 2 0 7fff
13 d8f0 00 1 0 0 3 0 8b1b
14 1234 00 1 0 0 0 0 1234
15 5a5a 00 1 0 0 0 1 1234
16 0100 04 1 0 2 0 0 0200

// ==== verif/pcxt_audio_sva.sv ====
// Audio path assertions on reset value, output select and compressed sign
`default_nettype none

module pcxt_audio_sva
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
(
	input logic          clk_chipset,
	input logic          reset,
	input comp_mode_t    comp_mode,
	input audio_sample_t mix,
	input audio_sample_t compressed,
	input audio_sample_t audio_out
);

	timeunit 1ns;
	timeprecision 100ps;

	// Assertion failures seen so far
	int fail_total = 0;

	a_reset_zero: assert property (@(posedge clk_chipset) reset |-> (audio_out == '0))
		else begin
			fail_total++;
			$error("audio_out not zero during reset");
		end

	// Bypass when the compressor is off
	a_bypass: assert property (@(posedge clk_chipset) disable iff (reset)
		(comp_mode == '0) |-> (audio_out == mix))
		else begin
			fail_total++;
			$error("audio_out differs from mix with compressor off");
		end

	// Compression never flips polarity
	a_sign_kept: assert property (@(posedge clk_chipset) disable iff (reset)
		(comp_mode != '0 && compressed != '0) |-> (compressed[15] == $past(mix[15])))
		else begin
			fail_total++;
			$error("compressed sample sign differs from mix");
		end

endmodule

bind pcxt_audio_top pcxt_audio_sva sva_i (
	.clk_chipset (clk_chipset),
	.reset       (reset),
	.comp_mode   (cfg.comp_mode),
	.mix         (mix),
	.compressed  (compressor_i.compressed),
	.audio_out   (audio_out)
);

`default_nettype wire

// ==== verif/pcxt_audio_tb.sv ====
// Trace-driven testbench for the audio path that replays source vectors and checks audio_out
`default_nettype none

module pcxt_audio_tb
	import audio_types_pkg::*;
	import audio_cfg_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HOLD_CYCLES     = 12;
	localparam int RESET_CYCLES    = 10;
	localparam int RESET_TIMEOUT   = 20;
	localparam int MAX_TRACE_LINES = 200;

	logic          clk_chipset = 1'b0;
	logic          reset;
	snd_src_t      src;
	audio_cfg_t    cfg;
	audio_sample_t audio_out;

	int tests_run;
	int fail_count;
	bit aborted;

	pcxt_audio_top dut_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.src         (src),
		.cfg         (cfg),
		.audio_out   (audio_out)
	);

	// 4 ns period
	always #2 clk_chipset = ~clk_chipset;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic release_reset();
		int cycles;
		cycles = 0;
		repeat (RESET_CYCLES) @(posedge clk_chipset);
		reset <= 1'b0;
		while (reset !== 1'b0 && !aborted) begin
			if (cycles >= RESET_TIMEOUT) begin
				$display("Timeout: reset still high after %0d cycles", cycles);
				aborted = 1'b1;
			end else begin
				@(negedge clk_chipset);
				cycles++;
			end
		end
	endtask

	// Holds one vector and flips fm to its inverse on odd cycles of a glitch vector
	task automatic apply_vector(input fm_sample_t fm, input psg_level_t psg,
			input logic speaker, input vol_shift_t spk_vol, input vol_shift_t psg_vol,
			input comp_mode_t comp_mode, input logic glitch);
		int c;
		for (c = 0; c < HOLD_CYCLES; c++) begin
			@(posedge clk_chipset);
			src.fm        <= (glitch && c[0]) ? ~fm : fm;
			src.psg       <= psg;
			src.speaker   <= speaker;
			cfg.spk_vol   <= spk_vol;
			cfg.psg_vol   <= psg_vol;
			cfg.comp_mode <= comp_mode;
		end
		// Sample away from the active edge
		@(negedge clk_chipset);
	endtask

	task automatic check_output(input int test_no, input audio_sample_t expected);
		bit ok;
		ok = 1'b1;
		assert (audio_out === expected) else begin
			$display("ERROR test %0d: audio_out expected %h actual %h",
				test_no, expected, audio_out);
			ok = 1'b0;
		end
		tests_run++;
		if (!ok)
			fail_count++;
		$display("Test %0d %s", test_no, ok ? "passed" : "failed");
	endtask

	task automatic run_trace();
		int          fd;
		int          lines;
		int          n;
		int          test_no;
		string       line;
		logic [31:0] v_fm, v_psg, v_spk, v_svol, v_pvol, v_comp, v_glitch, v_exp;
		fd = $fopen("verif/audio_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file verif/audio_trace.txt");
			aborted = 1'b1;
			return;
		end
		lines = 0;
		while (!$feof(fd) && !aborted) begin
			if (lines >= MAX_TRACE_LINES) begin
				$display("Timeout: trace file did not end within %0d lines", lines);
				aborted = 1'b1;
			end else begin
				lines++;
				n = $fgets(line, fd);
				// Skip comments and blank lines
				if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", test_no, v_fm, v_psg,
						v_spk, v_svol, v_pvol, v_comp, v_glitch, v_exp);
					if (n != 9) begin
						$display("Trace line %0d is malformed, %0d fields read", lines, n);
						aborted = 1'b1;
					end else begin
						apply_vector(v_fm[15:0], v_psg[7:0], v_spk[0], v_svol[1:0],
							v_pvol[1:0], v_comp[1:0], v_glitch[0]);
						check_output(test_no, v_exp[15:0]);
					end
				end
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset      = 1'b1;
		src        = '0;
		cfg        = '0;
		tests_run  = 0;
		fail_count = 0;
		aborted    = 1'b0;

		release_reset();
		// Test 0 is the value right after reset
		if (!aborted)
			check_output(0, 16'h0000);
		if (!aborted)
			run_trace();

		$display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
			tests_run, tests_run - fail_count, fail_count, dut_i.sva_i.fail_total);
		if (fail_count == 0 && !aborted && dut_i.sva_i.fail_total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
